/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= nf_cpu_tb
FILELIST  ?= nf_cpu.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/nf_cpu_params.svh */
// core-wide sizes; changing NF_XLEN away from 32 is not supported by the decoder
`ifndef NF_CPU_PARAMS_SVH
`define NF_CPU_PARAMS_SVH

// data and address width
`define NF_XLEN     32

// number of architectural registers, x0 included
`define NF_RF_DEPTH 32

// pc loaded while arst_n is low
`define NF_RESET_PC 32'h0000_0000

`endif

/* common/nf_cpu_pkg.sv */
// rv32i subset encodings only; values outside these enums decode as no-ops
`default_nettype none

package nf_cpu_pkg;

    // low two bits of the instruction word
    typedef enum logic [1:0] {
        RVC0 = 2'b00,       // compressed quadrants, not supported
        RVC1 = 2'b01,
        RVC2 = 2'b10,
        RVI  = 2'b11        // full 32-bit encoding
    } instr_type_e;

    // instr[6:2], the opcode above instr_type
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,   // lw
        OP_IMM    = 5'b00100,   // addi, slli
        OP_STORE  = 5'b01000,   // sw
        OP_R      = 5'b01100,   // add, sub, or
        OP_LUI    = 5'b01101,
        OP_BRANCH = 5'b11000    // beq
    } opcode_e;

    // alu operation codes
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_OR  = 3'd2,
        ALU_SLL = 3'd3,
        ALU_LUI = 3'd4      // passes src_b straight through
    } alu_op_e;

    // immediate format select
    typedef enum logic [1:0] {
        I_SEL = 2'd0,
        S_SEL = 2'd1,
        B_SEL = 2'd2,
        U_SEL = 2'd3
    } imm_sel_e;

    // write-back source
    typedef enum logic {
        RF_ALUR = 1'b0,     // alu result
        RF_DMEM = 1'b1      // data memory read
    } rf_src_e;

    // second alu operand
    typedef enum logic {
        SRCB_IMM = 1'b0,
        SRCB_RD2 = 1'b1
    } srcb_sel_e;

endpackage : nf_cpu_pkg

`default_nettype wire

/* nf_cpu.f */
+incdir+common
common/nf_cpu_pkg.sv
src/nf_control_unit.sv
src/nf_sign_ex.sv
src/nf_reg_file.sv
src/nf_alu.sv
src/nf_cpu.sv
verif/nf_cpu_properties.sv
verif/nf_cpu_tb.sv

/* src/nf_alu.sv */
// add, sub, or, sll and lui pass-through; zero flags operand equality regardless of alu_op
`timescale 1ns/1ps
`default_nettype none

`include "nf_cpu_params.svh"

module nf_alu
    import nf_cpu_pkg::*;
(
    input  logic [`NF_XLEN-1:0] src_a,
    input  logic [`NF_XLEN-1:0] src_b,
    input  alu_op_e             alu_op,
    output logic [`NF_XLEN-1:0] result,
    output logic                zero
);

    logic [4:0] shamt;

    assign shamt = src_b[4:0];  // slli shamt sits in imm[4:0]

    always_comb begin
        case (alu_op)
            ALU_ADD: result = src_a + src_b;
            ALU_SUB: result = src_a - src_b;
            ALU_OR:  result = src_a | src_b;
            ALU_SLL: result = src_a << shamt;
            ALU_LUI: result = src_b;            // upper immediate already placed
            default: result = '0;
        endcase
    end

    // beq runs as ALU_ADD, so equality cannot be taken from result
    assign zero = (src_a == src_b);

endmodule : nf_alu

`default_nettype wire

/* src/nf_control_unit.sv */
// decodes add, sub, or, slli, addi, lw, lui, beq and sw only; anything else leaves all writes off
`timescale 1ns/1ps
`default_nettype none

module nf_control_unit
    import nf_cpu_pkg::*;
(
    input  instr_type_e  instr_type,     // instr[1:0]
    input  opcode_e      opcode,         // instr[6:2]
    input  logic [2:0]   funct3,
    input  logic [6:0]   funct7,         // only bit 5 matters here
    output imm_sel_e     imm_src,
    output srcb_sel_e    srcb_sel,
    output logic         branch,
    output logic         we_rf,
    output logic         we_dm,
    output rf_src_e      rf_src,
    output alu_op_e      alu_op
);

    always_comb begin
        // inactive defaults, kept for any unmatched encoding
        imm_src  = I_SEL;
        srcb_sel = SRCB_IMM;
        branch   = 1'b0;
        we_rf    = 1'b0;
        we_dm    = 1'b0;
        rf_src   = RF_ALUR;
        alu_op   = ALU_ADD;

        if (instr_type == RVI) begin
            case (opcode)
                OP_R: begin
                    srcb_sel = SRCB_RD2;
                    case ({funct3, funct7[5]})
                        4'b000_0: begin we_rf = 1'b1; alu_op = ALU_ADD; end
                        4'b000_1: begin we_rf = 1'b1; alu_op = ALU_SUB; end
                        4'b110_0: begin we_rf = 1'b1; alu_op = ALU_OR;  end
                        default:  ;
                    endcase
                end
                OP_IMM: begin
                    casez ({funct3, funct7[5]})
                        4'b000_?: begin we_rf = 1'b1; alu_op = ALU_ADD; end   // addi
                        4'b001_0: begin we_rf = 1'b1; alu_op = ALU_SLL; end   // slli
                        default:  ;
                    endcase
                end
                OP_LOAD: begin
                    if (funct3 == 3'b010) begin     // lw
                        we_rf  = 1'b1;
                        rf_src = RF_DMEM;
                    end
                end
                OP_LUI: begin
                    we_rf   = 1'b1;
                    alu_op  = ALU_LUI;
                    imm_src = U_SEL;
                end
                OP_BRANCH: begin
                    if (funct3 == 3'b000) begin     // beq, compare via alu zero flag
                        branch   = 1'b1;
                        srcb_sel = SRCB_RD2;
                        imm_src  = B_SEL;
                    end
                end
                OP_STORE: begin
                    if (funct3 == 3'b010) begin     // sw
                        we_dm   = 1'b1;
                        imm_src = S_SEL;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule : nf_control_unit

`default_nettype wire

/* src/nf_cpu.sv */
// single-cycle core; memories must answer combinationally and the program must be word-aligned
`timescale 1ns/1ps
`default_nettype none

`include "nf_cpu_params.svh"

module nf_cpu
    import nf_cpu_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    output logic [`NF_XLEN-1:0] instr_addr,
    input  logic [`NF_XLEN-1:0] instr,
    output logic [`NF_XLEN-1:0] dm_addr,
    output logic [`NF_XLEN-1:0] dm_wd,
    output logic                dm_we,
    input  logic [`NF_XLEN-1:0] dm_rd
);

    // program counter
    logic [`NF_XLEN-1:0] pc;
    logic [`NF_XLEN-1:0] pc_plus4;
    logic [`NF_XLEN-1:0] pc_branch;
    logic [`NF_XLEN-1:0] pc_next;
    logic                take_branch;

    // instruction fields
    instr_type_e instr_type;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;

    // decoded controls
    imm_sel_e  imm_src;
    srcb_sel_e srcb_sel;
    logic      branch;
    logic      we_rf;
    logic      we_dm;
    rf_src_e   rf_src;
    alu_op_e   alu_op;

    // datapath
    logic [`NF_XLEN-1:0] imm;
    logic [`NF_XLEN-1:0] rd1;
    logic [`NF_XLEN-1:0] rd2;
    logic [`NF_XLEN-1:0] src_b;
    logic [`NF_XLEN-1:0] result;
    logic [`NF_XLEN-1:0] wb_data;
    logic                zero;

    assign instr_type = instr_type_e'(instr[1:0]);
    assign opcode     = opcode_e'(instr[6:2]);
    assign rd         = instr[11:7];
    assign funct3     = instr[14:12];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign funct7     = instr[31:25];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `NF_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign take_branch = branch & zero;         // beq only
    assign pc_plus4    = pc + `NF_XLEN'd4;
    assign pc_branch   = pc + imm;              // imm is the B immediate on beq
    assign pc_next     = take_branch ? pc_branch : pc_plus4;
    assign instr_addr  = pc;

    nf_control_unit u_control_unit (
        .instr_type (instr_type),
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7     (funct7),
        .imm_src    (imm_src),
        .srcb_sel   (srcb_sel),
        .branch     (branch),
        .we_rf      (we_rf),
        .we_dm      (we_dm),
        .rf_src     (rf_src),
        .alu_op     (alu_op)
    );

    nf_sign_ex u_sign_ex (
        .instr   (instr),
        .imm_src (imm_src),
        .imm     (imm)
    );

    nf_reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (rs1),
        .ra2    (rs2),
        .wa     (rd),
        .wd     (wb_data),
        .we     (we_rf),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    assign src_b = (srcb_sel == SRCB_RD2) ? rd2 : imm;

    nf_alu u_alu (
        .src_a  (rd1),
        .src_b  (src_b),
        .alu_op (alu_op),
        .result (result),
        .zero   (zero)
    );

    assign wb_data = (rf_src == RF_DMEM) ? dm_rd : result;

    // data memory side
    assign dm_addr = result;
    assign dm_wd   = rd2;
    assign dm_we   = we_dm & arst_n;    // no stores while reset is held

endmodule : nf_cpu

`default_nettype wire

/* src/nf_reg_file.sv */
// two async read ports, one write port on the rising edge; x0 always reads zero
`timescale 1ns/1ps
`default_nettype none

`include "nf_cpu_params.svh"

module nf_reg_file
(
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [$clog2(`NF_RF_DEPTH)-1:0]    ra1,
    input  logic [$clog2(`NF_RF_DEPTH)-1:0]    ra2,
    input  logic [$clog2(`NF_RF_DEPTH)-1:0]    wa,
    input  logic [`NF_XLEN-1:0]                wd,
    input  logic                               we,
    output logic [`NF_XLEN-1:0]                rd1,
    output logic [`NF_XLEN-1:0]                rd2
);

    logic [`NF_XLEN-1:0] regs [1:`NF_RF_DEPTH-1];  // no storage for x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `NF_RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin   // writes to x0 dropped
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule : nf_reg_file

`default_nettype wire

/* src/nf_sign_ex.sv */
// builds I, S, B and U immediates of a 32-bit word; J format is not handled
`timescale 1ns/1ps
`default_nettype none

`include "nf_cpu_params.svh"

module nf_sign_ex
    import nf_cpu_pkg::*;
(
    input  logic [`NF_XLEN-1:0] instr,
    input  imm_sel_e            imm_src,
    output logic [`NF_XLEN-1:0] imm
);

    logic sign;

    assign sign = instr[31];    // every format takes its sign from bit 31

    always_comb begin
        case (imm_src)
            I_SEL: imm = {{20{sign}}, instr[31:20]};
            S_SEL: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // branch offsets are in halfwords, bit 0 always zero
            B_SEL: imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            U_SEL: imm = {instr[31:12], 12'h000};
            default: imm = '0;
        endcase
    end

endmodule : nf_sign_ex

`default_nettype wire

/* verif/nf_cpu_properties.sv */
// checker bound into nf_cpu; rs1/rd1 there are the register file's ra1/rd1 nets
`timescale 1ns/1ps
`default_nettype none

`include "nf_cpu_params.svh"

module nf_cpu_properties (
    input logic        clk,
    input logic        arst_n,
    input logic [31:0] instr_addr,
    input logic        dm_we,
    input logic [4:0]  ra1,
    input logic [31:0] rd1
);

    // fetch address always on a word boundary
    assert property (@(posedge clk) instr_addr[1:0] == 2'b00)
        else $error("instr_addr not word-aligned");

    assert property (@(posedge clk) !arst_n |-> !dm_we)
        else $error("dm_we high during reset");

    // first edge after release still sees the reset pc
    assert property (@(posedge clk) $rose(arst_n) |-> instr_addr == `NF_RESET_PC)
        else $error("instr_addr left the reset pc too early");

    assert property (@(posedge clk) disable iff (!arst_n) (ra1 == 5'd0) |-> (rd1 == 32'd0))
        else $error("x0 read back nonzero");

endmodule : nf_cpu_properties

bind nf_cpu nf_cpu_properties u_properties (
    .clk        (clk),
    .arst_n     (arst_n),
    .instr_addr (instr_addr),
    .dm_we      (dm_we),
    .ra1        (rs1),
    .rd1        (rd1)
);

`default_nettype wire

/* verif/nf_cpu_tb.sv */
// one fixed-seed random program per run; memories are plain arrays answered combinationally
`timescale 1ns/1ps
`default_nettype none

`include "nf_cpu_params.svh"

module nf_cpu_tb;

    localparam int          CLK_PERIOD      = 100;
    localparam int          PROG_LEN        = 200;
    localparam int          IMEM_WORDS      = 512;
    localparam int          DMEM_WORDS      = 64;
    localparam int          FINAL_BASE      = 32;      // x1..x31 dumped to words 33..63
    localparam int          TAIL_CYCLES     = 4;
    localparam int          WATCHDOG_CYCLES = PROG_LEN + 31 + 50;
    localparam logic [31:0] LFSR_SEED       = 32'h9fb9_1a04;
    localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;

    logic        clk;
    logic        arst_n;
    logic [31:0] instr_addr;
    logic [31:0] instr;
    logic [31:0] dm_addr;
    logic [31:0] dm_wd;
    logic        dm_we;
    logic [31:0] dm_rd;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];

    // reference model state
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [DMEM_WORDS];
    logic [31:0] m_pc;
    logic [31:0] lfsr;

    int err_reset;
    int err_flow;
    int err_store;
    int err_regs;
    int err_mem;

    nf_cpu u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_addr (instr_addr),
        .instr      (instr),
        .dm_addr    (dm_addr),
        .dm_wd      (dm_wd),
        .dm_we      (dm_we),
        .dm_rd      (dm_rd)
    );

    assign instr = imem[instr_addr[10:2]];
    assign dm_rd = dmem[dm_addr[7:2]];

    always @(posedge clk) begin
        if (dm_we) begin
            dmem[dm_addr[7:2]] <= dm_wd;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the program did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_beq(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic build_program();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        int          words;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = enc_i(i[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011);  // addi x0 nop
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            kind  = 4'(take_bits(4));
            rd    = 5'(take_bits(5));
            rs1   = 5'(take_bits(5));
            rs2   = 5'(take_bits(5));
            imm12 = 12'(take_bits(12));
            case (kind)
                4'd0: imem[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);     // add
                4'd1: imem[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);     // sub
                4'd2: imem[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);     // or
                4'd3: imem[i] = enc_i({7'h00, imm12[4:0]}, rs1, 3'b001, rd, 7'b0010011);
                4'd4: imem[i] = {imm12, rs2, rs1[2:0], rd, 7'b0110111};  // lui
                4'd5: imem[i] = enc_i({4'd0, imm12[5:0], 2'b00}, 5'd0, 3'b010, rd, 7'b0000011);
                4'd6: imem[i] = enc_sw({4'd0, imm12[5:0], 2'b00}, rs2, 5'd0);
                4'd7: begin
                    if (i <= PROG_LEN - 8) begin    // target never past the final stores
                        words = 2 + int'(imm12[2:0]) % 7;
                        if (imm12[3]) begin
                            rs2 = rs1;              // forces a taken branch
                        end
                        imem[i] = enc_beq(13'(words * 4), rs2, rs1);
                    end else begin
                        imem[i] = enc_i(imm12, rs1, 3'b000, rd, 7'b0010011);
                    end
                end
                4'd8: begin
                    if (imm12[0]) begin
                        imem[i] = {3'b101, rs1, rs2, imm12, rd, 2'b00};  // compressed space
                    end else begin
                        imem[i] = {imm12, rs1, rs2, 3'b000, 7'b1101111}; // jal, unsupported
                    end
                end
                default: imem[i] = enc_i(imm12, rs1, 3'b000, rd, 7'b0010011);    // addi
            endcase
        end
        // store at the reset pc, so we_dm is high while arst_n is low
        imem[0] = enc_sw(12'd0, 5'd0, 5'd0);
        for (int k = 1; k < 32; k++) begin
            imem[PROG_LEN + k - 1] = enc_sw(12'((FINAL_BASE + k) * 4), 5'(k), 5'd0);
        end
    endtask

    task automatic show_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("Fail at time %0t: %s = %h, expected %h", $time, sig, got, exp);
    endtask

    task automatic report_test(input string name, input int errs);
        $display("test %-10s %s, %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
    endtask

    // compares the DUT against the model for the current cycle, then runs one instruction
    task automatic check_and_step();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic        is_sw;
        logic        final_sw;
        w        = imem[m_pc[10:2]];
        op       = w[6:0];
        rd       = w[11:7];
        f3       = w[14:12];
        f7       = w[31:25];
        a        = m_regs[w[19:15]];
        b        = m_regs[w[24:20]];
        next_pc  = m_pc + 32'd4;
        is_sw    = (op == 7'b0100011) && (f3 == 3'b010);
        final_sw = is_sw && (m_pc >= 32'(PROG_LEN * 4));
        if (instr_addr !== m_pc) begin
            err_flow++;
            show_mismatch("instr_addr", instr_addr, m_pc);
        end
        if (is_sw) begin
            addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
            if (dm_we !== 1'b1) begin
                err_store++;
                show_mismatch("dm_we", {31'd0, dm_we}, 32'd1);
            end
            if (dm_addr !== addr) begin
                err_store++;
                show_mismatch("dm_addr", dm_addr, addr);
            end
            if (dm_wd !== b) begin
                if (final_sw) begin
                    err_regs++;
                end else begin
                    err_store++;
                end
                show_mismatch("dm_wd", dm_wd, b);
            end
            m_mem[addr[7:2]] = b;
        end else if (dm_we !== 1'b0) begin
            err_store++;
            show_mismatch("dm_we", {31'd0, dm_we}, 32'd0);
        end
        case (op)
            7'b0110011: begin
                if (f3 == 3'b000 && f7 == 7'h00) m_regs[rd] = a + b;
                if (f3 == 3'b000 && f7 == 7'h20) m_regs[rd] = a - b;
                if (f3 == 3'b110 && f7 == 7'h00) m_regs[rd] = a | b;
            end
            7'b0010011: begin
                if (f3 == 3'b000) m_regs[rd] = a + {{20{w[31]}}, w[31:20]};
                if (f3 == 3'b001 && f7 == 7'h00) m_regs[rd] = a << w[24:20];
            end
            7'b0000011: begin
                if (f3 == 3'b010) m_regs[rd] = m_mem[(a + {{20{w[31]}}, w[31:20]}) >> 2 & 32'h3f];
            end
            7'b0110111: m_regs[rd] = {w[31:12], 12'h000};
            7'b1100011: begin
                if (f3 == 3'b000 && a == b) begin
                    next_pc = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        m_regs[0] = '0;     // x0 writes vanish
        m_pc      = next_pc;
    endtask

    initial begin
        int total;
        int failed_tests;
        arst_n    = 1'b0;
        lfsr      = LFSR_SEED;
        err_reset = 0;
        err_flow  = 0;
        err_store = 0;
        err_regs  = 0;
        err_mem   = 0;
        build_program();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]  = {2{i[7:0], ~i[7:0]}} ^ 32'h5a0f_c3e1;
            m_mem[i] = dmem[i];
        end
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end
        m_pc = `NF_RESET_PC;

        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (instr_addr !== `NF_RESET_PC) begin
                err_reset++;
                show_mismatch("instr_addr", instr_addr, `NF_RESET_PC);
            end
            if (dm_we !== 1'b0) begin
                err_reset++;
                show_mismatch("dm_we", {31'd0, dm_we}, 32'd0);
            end
        end
        @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);     // first cycle out of reset
        if (instr_addr !== `NF_RESET_PC) begin
            err_reset++;
            show_mismatch("instr_addr", instr_addr, `NF_RESET_PC);
        end
        report_test("reset", err_reset);
        check_and_step();

        while (m_pc < 32'((PROG_LEN + 31) * 4)) begin
            @(negedge clk);
            check_and_step();
        end
        for (int i = 0; i < TAIL_CYCLES; i++) begin
            @(negedge clk);
            check_and_step();
        end
        report_test("flow", err_flow);
        report_test("stores", err_store);
        report_test("registers", err_regs);

        for (int i = 0; i < DMEM_WORDS; i++) begin
            if (dmem[i] !== m_mem[i]) begin
                err_mem++;
                show_mismatch($sformatf("dmem[%0d]", i), dmem[i], m_mem[i]);
            end
        end
        report_test("memory", err_mem);

        total        = err_reset + err_flow + err_store + err_regs + err_mem;
        failed_tests = int'(err_reset != 0) + int'(err_flow != 0) + int'(err_store != 0)
                     + int'(err_regs != 0) + int'(err_mem != 0);
        $display("summary: 5 tests, %0d passed, %0d failed, %0d errors",
                 5 - failed_tests, failed_tests, total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : nf_cpu_tb

`default_nettype wire
